// ==== design/axi_host_pkg.sv ====
// Host memory bus definitions shared by the traffic engines, the top level and the testbench
`default_nettype none

package axi_host_pkg;

  //------------------------------
  // Bus geometry
  //------------------------------
  localparam int HOST_ADDR_W = 32;
  localparam int HOST_DATA_W = 32;
  localparam int BURST_BEATS = 4;
  localparam int BEAT_CNT_W  = $clog2(BURST_BEATS);
  localparam int BURST_SHIFT = 4;                   // 16 bytes per burst

  localparam logic [1:0] RESP_OKAY = 2'd0;

  // Address channel payload, shared by AW and AR
  typedef struct packed {
    logic [HOST_ADDR_W-1:0] addr;
    logic [7:0]             len;     // Beats minus one
  } host_addr_t;

  typedef struct packed {
    logic [HOST_DATA_W-1:0] data;
    logic                   last;
  } host_wdata_t;

  typedef struct packed {
    logic [HOST_DATA_W-1:0] data;
    logic [1:0]             resp;
    logic                   last;
  } host_rdata_t;

endpackage

`default_nettype wire

// ==== design/ctrl_regs.sv ====
// Control register bank: settings, start pulse, sticky status and bus handshake counters
`timescale 1ns/1ns
`default_nettype none

module ctrl_regs (
  input  wire                       clk,
  input  wire                       i_rst,
  input  engine_pkg::reg_req_t      i_reg_req,
  output engine_pkg::reg_rsp_t      o_reg_rsp,
  output logic                      o_start,
  output engine_pkg::eng_cfg_t      o_wr_cfg,
  output engine_pkg::eng_cfg_t      o_rd_cfg,
  input  engine_pkg::eng_status_t   i_wr_status,
  input  engine_pkg::eng_status_t   i_rd_status,
  input  wire                       i_ar_valid,
  input  wire                       i_ar_ready,
  input  wire                       i_r_valid,
  input  wire                       i_r_ready,
  input  wire                       i_r_last,
  input  wire                       i_aw_valid,
  input  wire                       i_aw_ready,
  input  wire                       i_b_valid,
  input  wire                       i_b_ready,
  input  wire [31:0]                i_action_type,
  input  wire [31:0]                i_action_version
);
  import engine_pkg::*;

  logic        wrap_mode;
  logic [3:0]  wrap_len;
  logic [31:0] src_addr, tgt_addr;
  logic [31:0] wr_init, rd_init, wr_num, rd_num;
  logic [1:0]  wr_pat, rd_pat;
  logic        wr_done, rd_done, err_seen;
  logic [1:0]  wr_err, rd_err;
  logic [31:0] err_addr, err_data;
  logic [31:0] ar_cnt, r_cnt, aw_cnt, b_cnt;
  logic [31:0] rd_mux;

  //------------------------------
  // Register writes
  //------------------------------
  always_ff @(posedge clk) begin
    if (i_rst) begin
      o_start   <= 1'b0;
      wrap_mode <= 1'b0;
      wrap_len  <= '0;
      src_addr  <= '0;
      tgt_addr  <= '0;
      wr_init   <= '0;
      rd_init   <= '0;
      wr_pat    <= PAT_CONST;
      rd_pat    <= PAT_CONST;
      wr_num    <= '0;
      rd_num    <= '0;
    end else begin
      o_start <= i_reg_req.wr && (i_reg_req.addr == REG_CTRL) && i_reg_req.wdata[0];
      if (i_reg_req.wr) begin
        case (i_reg_req.addr)
          REG_CFG: begin
            wrap_mode <= i_reg_req.wdata[0];
            wrap_len  <= i_reg_req.wdata[7:4];
          end
          REG_SRC:     src_addr <= i_reg_req.wdata;
          REG_TGT:     tgt_addr <= i_reg_req.wdata;
          REG_WR_INIT: wr_init  <= i_reg_req.wdata;
          REG_RD_INIT: rd_init  <= i_reg_req.wdata;
          REG_WR_PAT:  wr_pat   <= i_reg_req.wdata[1:0];
          REG_RD_PAT:  rd_pat   <= i_reg_req.wdata[1:0];
          REG_WR_NUM:  wr_num   <= i_reg_req.wdata;
          REG_RD_NUM:  rd_num   <= i_reg_req.wdata;
          default: ;
        endcase
      end
    end
  end

  // Writes go to the target area, reads come from the source area
  assign o_wr_cfg = '{base: tgt_addr, init: wr_init, pattern: wr_pat, num: wr_num,
                      wrap_mode: wrap_mode, wrap_len: wrap_len};
  assign o_rd_cfg = '{base: src_addr, init: rd_init, pattern: rd_pat, num: rd_num,
                      wrap_mode: wrap_mode, wrap_len: wrap_len};

  //------------------------------
  // Sticky status and counters
  //------------------------------
  always_ff @(posedge clk) begin
    if (i_rst || o_start) begin
      wr_done  <= 1'b0;
      rd_done  <= 1'b0;
      wr_err   <= '0;
      rd_err   <= '0;
      err_seen <= 1'b0;
      ar_cnt   <= '0;
      r_cnt    <= '0;
      aw_cnt   <= '0;
      b_cnt    <= '0;
    end else begin
      if (i_wr_status.done) begin
        wr_done <= 1'b1;
        wr_err  <= i_wr_status.error;
      end
      if (i_rd_status.done) begin
        rd_done <= 1'b1;
        rd_err  <= i_rd_status.error;
      end
      if ((i_wr_status.done && |i_wr_status.error) ||
          (i_rd_status.done && |i_rd_status.error)) begin
        err_seen <= 1'b1;
      end
      ar_cnt <= ar_cnt + 32'(i_ar_valid && i_ar_ready);
      r_cnt  <= r_cnt + 32'(i_r_valid && i_r_ready && i_r_last);   // Bursts, not beats
      aw_cnt <= aw_cnt + 32'(i_aw_valid && i_aw_ready);
      b_cnt  <= b_cnt + 32'(i_b_valid && i_b_ready);
    end
  end

  // First failing direction keeps its info until the next start
  always_ff @(posedge clk) begin
    if (!err_seen) begin
      if (i_rd_status.done && |i_rd_status.error) begin
        err_addr <= i_rd_status.err_addr;
        err_data <= i_rd_status.err_data;
      end else if (i_wr_status.done && |i_wr_status.error) begin
        err_addr <= i_wr_status.err_addr;
        err_data <= i_wr_status.err_data;
      end
    end
  end

  //------------------------------
  // Register reads
  //------------------------------
  always_comb begin
    case (i_reg_req.addr)
      REG_CFG:      rd_mux = {24'b0, wrap_len, 3'b0, wrap_mode};
      REG_SRC:      rd_mux = src_addr;
      REG_TGT:      rd_mux = tgt_addr;
      REG_WR_INIT:  rd_mux = wr_init;
      REG_RD_INIT:  rd_mux = rd_init;
      REG_WR_PAT:   rd_mux = {30'b0, wr_pat};
      REG_RD_PAT:   rd_mux = {30'b0, rd_pat};
      REG_WR_NUM:   rd_mux = wr_num;
      REG_RD_NUM:   rd_mux = rd_num;
      REG_STATUS:   rd_mux = {26'b0, rd_err, wr_err, rd_done, wr_done};
      REG_ERR_ADDR: rd_mux = err_seen ? err_addr : 32'b0;
      REG_ERR_DATA: rd_mux = err_seen ? err_data : 32'b0;
      REG_AR_CNT:   rd_mux = ar_cnt;
      REG_R_CNT:    rd_mux = r_cnt;
      REG_AW_CNT:   rd_mux = aw_cnt;
      REG_B_CNT:    rd_mux = b_cnt;
      REG_TYPE:     rd_mux = i_action_type;
      REG_VER:      rd_mux = i_action_version;
      default:      rd_mux = 32'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (i_rst) begin
      o_reg_rsp.valid <= 1'b0;
    end else begin
      o_reg_rsp.valid <= i_reg_req.rd;
    end
    o_reg_rsp.rdata <= rd_mux;   // Payload only, qualified by valid
  end

endmodule

`default_nettype wire

// ==== design/engine_pkg.sv ====
// Register map, pattern codes and the config and status records passed between bank and engines
`default_nettype none

package engine_pkg;

  //------------------------------
  // Register byte addresses
  //------------------------------
  localparam logic [7:0] REG_CTRL     = 8'h00;  // Bit 0 starts both engines
  localparam logic [7:0] REG_CFG      = 8'h04;  // Bit 0 wrap mode, bits 7:4 wrap length
  localparam logic [7:0] REG_SRC      = 8'h08;
  localparam logic [7:0] REG_TGT      = 8'h0C;
  localparam logic [7:0] REG_WR_INIT  = 8'h10;
  localparam logic [7:0] REG_RD_INIT  = 8'h14;
  localparam logic [7:0] REG_WR_PAT   = 8'h18;
  localparam logic [7:0] REG_RD_PAT   = 8'h1C;
  localparam logic [7:0] REG_WR_NUM   = 8'h20;
  localparam logic [7:0] REG_RD_NUM   = 8'h24;
  localparam logic [7:0] REG_STATUS   = 8'h28;
  localparam logic [7:0] REG_ERR_ADDR = 8'h2C;
  localparam logic [7:0] REG_ERR_DATA = 8'h30;
  localparam logic [7:0] REG_AR_CNT   = 8'h34;
  localparam logic [7:0] REG_R_CNT    = 8'h38;
  localparam logic [7:0] REG_AW_CNT   = 8'h3C;
  localparam logic [7:0] REG_B_CNT    = 8'h40;
  localparam logic [7:0] REG_TYPE     = 8'h44;
  localparam logic [7:0] REG_VER      = 8'h48;

  localparam logic [1:0] PAT_CONST = 2'd0;
  localparam logic [1:0] PAT_INCR  = 2'd1;

  typedef struct packed {
    logic        wr;
    logic        rd;
    logic [7:0]  addr;
    logic [31:0] wdata;
  } reg_req_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] rdata;
  } reg_rsp_t;

  // Settings for one direction
  typedef struct packed {
    logic [axi_host_pkg::HOST_ADDR_W-1:0] base;
    logic [31:0]                          init;
    logic [1:0]                           pattern;
    logic [31:0]                          num;      // Bursts in the run
    logic                                 wrap_mode;
    logic [3:0]                           wrap_len;
  } eng_cfg_t;

  typedef struct packed {
    logic                                 done;     // One-cycle pulse
    logic [1:0]                           error;    // Bit 0 mismatch, bit 1 error response
    logic [axi_host_pkg::HOST_ADDR_W-1:0] err_addr;
    logic [31:0]                          err_data;
  } eng_status_t;

endpackage

`default_nettype wire

// ==== design/hdl_computing.sv ====
// Top level of the traffic engine: register bank plus write and read masters on the host bus
`timescale 1ns/1ns
`default_nettype none

module hdl_computing (
  input  wire                         clk,
  input  wire                         i_rst,
  input  engine_pkg::reg_req_t        i_reg_req,
  output engine_pkg::reg_rsp_t        o_reg_rsp,
  // Write address, data and response
  output axi_host_pkg::host_addr_t    o_aw,
  output logic                        o_aw_valid,
  input  wire                         i_aw_ready,
  output axi_host_pkg::host_wdata_t   o_w,
  output logic                        o_w_valid,
  input  wire                         i_w_ready,
  input  wire [1:0]                   i_b_resp,
  input  wire                         i_b_valid,
  output logic                        o_b_ready,
  // Read address and data
  output axi_host_pkg::host_addr_t    o_ar,
  output logic                        o_ar_valid,
  input  wire                         i_ar_ready,
  input  axi_host_pkg::host_rdata_t   i_r,
  input  wire                         i_r_valid,
  output logic                        o_r_ready,
  input  wire [31:0]                  i_action_type,
  input  wire [31:0]                  i_action_version
);
  import engine_pkg::*;

  logic        start;
  eng_cfg_t    wr_cfg, rd_cfg;
  eng_status_t wr_status, rd_status;

  //------------------------------
  // Register hub
  //------------------------------
  ctrl_regs u_ctrl_regs (
    .clk              (clk),
    .i_rst            (i_rst),
    .i_reg_req        (i_reg_req),
    .o_reg_rsp        (o_reg_rsp),
    .o_start          (start),
    .o_wr_cfg         (wr_cfg),
    .o_rd_cfg         (rd_cfg),
    .i_wr_status      (wr_status),
    .i_rd_status      (rd_status),
    .i_ar_valid       (o_ar_valid),
    .i_ar_ready       (i_ar_ready),
    .i_r_valid        (i_r_valid),
    .i_r_ready        (o_r_ready),
    .i_r_last         (i_r.last),       // Counts bursts on the R channel
    .i_aw_valid       (o_aw_valid),
    .i_aw_ready       (i_aw_ready),
    .i_b_valid        (i_b_valid),
    .i_b_ready        (o_b_ready),
    .i_action_type    (i_action_type),
    .i_action_version (i_action_version)
  );

  //------------------------------
  // Host bus masters
  //------------------------------
  host_wr_engine u_host_wr_engine (
    .clk        (clk),
    .i_rst      (i_rst),
    .i_start    (start),
    .i_cfg      (wr_cfg),
    .o_status   (wr_status),
    .o_aw       (o_aw),
    .o_aw_valid (o_aw_valid),
    .i_aw_ready (i_aw_ready),
    .o_w        (o_w),
    .o_w_valid  (o_w_valid),
    .i_w_ready  (i_w_ready),
    .i_b_resp   (i_b_resp),
    .i_b_valid  (i_b_valid),
    .o_b_ready  (o_b_ready)
  );

  host_rd_engine u_host_rd_engine (
    .clk        (clk),
    .i_rst      (i_rst),
    .i_start    (start),
    .i_cfg      (rd_cfg),
    .o_status   (rd_status),
    .o_ar       (o_ar),
    .o_ar_valid (o_ar_valid),
    .i_ar_ready (i_ar_ready),
    .i_r        (i_r),
    .i_r_valid  (i_r_valid),
    .o_r_ready  (o_r_ready)
  );

endmodule

`default_nettype wire

// ==== design/host_rd_engine.sv ====
// Read master: fetches bursts from host memory and compares each beat with the expected pattern
`timescale 1ns/1ns
`default_nettype none

module host_rd_engine (
  input  wire                         clk,
  input  wire                         i_rst,
  input  wire                         i_start,
  input  engine_pkg::eng_cfg_t        i_cfg,
  output engine_pkg::eng_status_t     o_status,
  output axi_host_pkg::host_addr_t    o_ar,
  output logic                        o_ar_valid,
  input  wire                         i_ar_ready,
  input  axi_host_pkg::host_rdata_t   i_r,
  input  wire                         i_r_valid,
  output logic                        o_r_ready
);
  import axi_host_pkg::*;
  import engine_pkg::*;

  typedef enum logic [1:0] {S_IDLE, S_AR, S_R} state_t;

  state_t                 state;
  eng_cfg_t               cfg_q;
  logic [31:0]            burst_cnt;
  logic [31:0]            slot;
  logic [BEAT_CNT_W-1:0]  beat;
  logic [31:0]            expect_q;       // Next expected word
  logic                   done_q;
  logic [1:0]             err_q;
  logic [HOST_ADDR_W-1:0] err_addr_q;
  logic [31:0]            err_data_q;
  logic [HOST_ADDR_W-1:0] burst_addr;
  logic [HOST_ADDR_W-1:0] beat_addr;

  assign burst_addr = cfg_q.base + (slot << BURST_SHIFT);
  assign beat_addr  = burst_addr + {{(HOST_ADDR_W-BEAT_CNT_W-2){1'b0}}, beat, 2'b00};

  //------------------------------
  // Burst sequencing and check
  //------------------------------
  always_ff @(posedge clk) begin
    if (i_rst) begin
      state     <= S_IDLE;
      done_q    <= 1'b0;
      err_q     <= '0;
      burst_cnt <= '0;
      slot      <= '0;
      beat      <= '0;
    end else begin
      done_q <= 1'b0;
      case (state)
        S_IDLE: if (i_start) begin
          cfg_q     <= i_cfg;
          err_q     <= '0;
          burst_cnt <= '0;
          slot      <= '0;
          beat      <= '0;
          expect_q  <= i_cfg.init;
          if (i_cfg.num == 32'd0) done_q <= 1'b1;
          else                    state  <= S_AR;
        end
        S_AR: if (i_ar_ready) state <= S_R;
        S_R: if (i_r_valid) begin
          beat <= beat + 1'b1;
          if (cfg_q.pattern == PAT_INCR) expect_q <= expect_q + 32'd1;
          // Only the first mismatch of the run is kept
          if (i_r.data != expect_q && !err_q[0]) begin
            err_q[0]   <= 1'b1;
            err_addr_q <= beat_addr;
            err_data_q <= i_r.data;
          end
          if (i_r.resp != RESP_OKAY) err_q[1] <= 1'b1;
          if (i_r.last) begin
            beat      <= '0;
            burst_cnt <= burst_cnt + 32'd1;
            if (cfg_q.wrap_mode && slot == 32'(cfg_q.wrap_len)) slot <= '0;
            else                                                slot <= slot + 32'd1;
            if (burst_cnt + 32'd1 == cfg_q.num) begin
              done_q <= 1'b1;
              state  <= S_IDLE;
            end else begin
              state <= S_AR;
            end
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  assign o_ar_valid = (state == S_AR);
  assign o_ar       = '{addr: burst_addr, len: 8'(BURST_BEATS - 1)};
  assign o_r_ready  = (state == S_R);      // Open burst accepts every beat

  assign o_status = '{done: done_q, error: err_q, err_addr: err_addr_q, err_data: err_data_q};

endmodule

`default_nettype wire

// ==== design/host_wr_engine.sv ====
// Write master: sends pattern bursts to host memory, one burst at a time, and checks responses
`timescale 1ns/1ns
`default_nettype none

module host_wr_engine (
  input  wire                         clk,
  input  wire                         i_rst,
  input  wire                         i_start,
  input  engine_pkg::eng_cfg_t        i_cfg,
  output engine_pkg::eng_status_t     o_status,
  output axi_host_pkg::host_addr_t    o_aw,
  output logic                        o_aw_valid,
  input  wire                         i_aw_ready,
  output axi_host_pkg::host_wdata_t   o_w,
  output logic                        o_w_valid,
  input  wire                         i_w_ready,
  input  wire [1:0]                   i_b_resp,
  input  wire                         i_b_valid,
  output logic                        o_b_ready
);
  import axi_host_pkg::*;
  import engine_pkg::*;

  typedef enum logic [1:0] {S_IDLE, S_AW, S_W, S_B} state_t;

  state_t                 state;
  eng_cfg_t               cfg_q;          // Settings latched at start
  logic [31:0]            burst_cnt;
  logic [31:0]            slot;           // Burst index after wrap
  logic [BEAT_CNT_W-1:0]  beat;
  logic [31:0]            wdata_q;
  logic                   done_q;
  logic [1:0]             err_q;
  logic [HOST_ADDR_W-1:0] err_addr_q;
  logic [HOST_ADDR_W-1:0] burst_addr;
  logic                   beat_last;

  assign burst_addr = cfg_q.base + (slot << BURST_SHIFT);
  assign beat_last  = (beat == BEAT_CNT_W'(BURST_BEATS - 1));

  //------------------------------
  // Burst sequencing
  //------------------------------
  always_ff @(posedge clk) begin
    if (i_rst) begin
      state     <= S_IDLE;
      done_q    <= 1'b0;
      err_q     <= '0;
      burst_cnt <= '0;
      slot      <= '0;
      beat      <= '0;
    end else begin
      done_q <= 1'b0;
      case (state)
        S_IDLE: if (i_start) begin
          cfg_q     <= i_cfg;
          err_q     <= '0;
          burst_cnt <= '0;
          slot      <= '0;
          beat      <= '0;
          wdata_q   <= i_cfg.init;
          if (i_cfg.num == 32'd0) done_q <= 1'b1;   // Empty run
          else                    state  <= S_AW;
        end
        S_AW: if (i_aw_ready) state <= S_W;
        S_W: if (i_w_ready) begin
          beat <= beat + 1'b1;
          if (cfg_q.pattern == PAT_INCR) wdata_q <= wdata_q + 32'd1;
          if (beat_last) state <= S_B;
        end
        S_B: if (i_b_valid) begin
          if (i_b_resp != RESP_OKAY && !err_q[1]) begin
            err_q[1]   <= 1'b1;
            err_addr_q <= burst_addr;
          end
          burst_cnt <= burst_cnt + 32'd1;
          if (cfg_q.wrap_mode && slot == 32'(cfg_q.wrap_len)) slot <= '0;
          else                                                slot <= slot + 32'd1;
          if (burst_cnt + 32'd1 == cfg_q.num) begin
            done_q <= 1'b1;
            state  <= S_IDLE;
          end else begin
            state <= S_AW;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // Channel outputs follow the state directly
  assign o_aw_valid = (state == S_AW);
  assign o_aw       = '{addr: burst_addr, len: 8'(BURST_BEATS - 1)};
  assign o_w_valid  = (state == S_W);
  assign o_w        = '{data: wdata_q, last: beat_last};
  assign o_b_ready  = (state == S_B);

  assign o_status = '{done: done_q, error: err_q, err_addr: err_addr_q, err_data: 32'b0};

endmodule

`default_nettype wire

// ==== list.f ====
design/axi_host_pkg.sv
design/engine_pkg.sv
design/ctrl_regs.sv
design/host_wr_engine.sv
design/host_rd_engine.sv
design/hdl_computing.sv
tests/hdl_computing_properties.sv
tests/tb_hdl_computing.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the traffic engine simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module tb_hdl_computing -o sim_tb

# The simulation may stop on an assertion, so the log decides the result
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "^Result: PASSED$" sim.log; then
  exit 0
fi
exit 1

// ==== tests/hdl_computing_properties.sv ====
// Bus handshake and pulse assertions, bound into the traffic engine top level
`timescale 1ns/1ns
`default_nettype none

module hdl_computing_properties (
  input wire                       clk,
  input wire                       i_rst,
  input axi_host_pkg::host_addr_t  i_aw,
  input wire                       i_aw_valid,
  input wire                       i_aw_ready,
  input axi_host_pkg::host_wdata_t i_w,
  input wire                       i_w_valid,
  input wire                       i_w_ready,
  input axi_host_pkg::host_addr_t  i_ar,
  input wire                       i_ar_valid,
  input wire                       i_ar_ready,
  input wire                       i_wr_done,
  input wire                       i_rd_done
);
  logic [3:0] w_beats;   // W beats since the last AW handshake
  int         fail_cnt = 0;   // Failed assertions, read by the testbench

  always_ff @(posedge clk) begin
    if (i_rst) begin
      w_beats <= '0;
    end else if (i_aw_valid && i_aw_ready) begin
      w_beats <= '0;
    end else if (i_w_valid && i_w_ready) begin
      w_beats <= w_beats + 4'd1;
    end
  end

  //------------------------------
  // Stable payloads under stall
  //------------------------------
  assert property (@(posedge clk) disable iff (i_rst)
    i_aw_valid && !i_aw_ready |=> i_aw_valid && $stable(i_aw))
  else begin
    fail_cnt++;
    $error("AW payload moved");
  end
  assert property (@(posedge clk) disable iff (i_rst)
    i_w_valid && !i_w_ready |=> i_w_valid && $stable(i_w))
  else begin
    fail_cnt++;
    $error("W payload moved");
  end
  assert property (@(posedge clk) disable iff (i_rst)
    i_ar_valid && !i_ar_ready |=> i_ar_valid && $stable(i_ar))
  else begin
    fail_cnt++;
    $error("AR payload moved");
  end

  assert property (@(posedge clk) disable iff (i_rst) i_wr_done |=> !i_wr_done)
  else begin
    fail_cnt++;
    $error("Write done longer than one cycle");
  end
  assert property (@(posedge clk) disable iff (i_rst) i_rd_done |=> !i_rd_done)
  else begin
    fail_cnt++;
    $error("Read done longer than one cycle");
  end
  assert property (@(posedge clk) disable iff (i_rst) w_beats <= 4'd4)
  else begin
    fail_cnt++;
    $error("Too many W beats for one burst");
  end

  // Valids low once reset has been sampled
  assert property (@(posedge clk) i_rst |=> !i_aw_valid && !i_w_valid && !i_ar_valid)
  else begin
    fail_cnt++;
    $error("Valid high during reset");
  end

endmodule

`default_nettype wire

// ==== tests/tb_hdl_computing.sv ====
// Testbench for the traffic engine: host memory model, directed register tests and the result line
`timescale 1ns/1ns
`default_nettype none

module tb_hdl_computing;
  import axi_host_pkg::*;
  import engine_pkg::*;

  localparam int MAX_CYCLES = 20000;

  logic clk = 1'b0;
  logic rst;
  reg_req_t req;
  reg_rsp_t rsp;
  host_addr_t aw, ar;
  host_wdata_t w;
  host_rdata_t r;
  logic aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
  logic ar_valid, ar_ready, r_valid, r_ready;
  logic [1:0] b_resp;
  logic [31:0] mem [0:255];                // Host memory, word indexed
  logic [7:0] wr_idx, rd_idx;
  int rd_beat, wr_beat, errors, cycles;
  logic b_pend, r_pend, force_b_err, force_r_err;

  hdl_computing i_hdl_computing (
    .clk(clk), .i_rst(rst), .i_reg_req(req), .o_reg_rsp(rsp),
    .o_aw(aw), .o_aw_valid(aw_valid), .i_aw_ready(aw_ready),
    .o_w(w), .o_w_valid(w_valid), .i_w_ready(w_ready),
    .i_b_resp(b_resp), .i_b_valid(b_valid), .o_b_ready(b_ready),
    .o_ar(ar), .o_ar_valid(ar_valid), .i_ar_ready(ar_ready),
    .i_r(r), .i_r_valid(r_valid), .o_r_ready(r_ready),
    .i_action_type(32'h0000_10c5), .i_action_version(32'h0002_0001)
  );

  bind hdl_computing hdl_computing_properties u_props (
    .clk(clk), .i_rst(i_rst), .i_aw(o_aw), .i_aw_valid(o_aw_valid), .i_aw_ready(i_aw_ready),
    .i_w(o_w), .i_w_valid(o_w_valid), .i_w_ready(i_w_ready),
    .i_ar(o_ar), .i_ar_valid(o_ar_valid), .i_ar_ready(i_ar_ready),
    .i_wr_done(wr_status.done), .i_rd_done(rd_status.done)
  );

  initial begin
    forever #10 clk = ~clk;
  end

  //------------------------------
  // Host memory model
  //------------------------------
  always @(negedge clk) begin
    if (rst) begin
      {aw_ready, w_ready, b_valid, ar_ready, r_valid} = '0;
      b_pend = 1'b0;
      r_pend = 1'b0;
    end else begin
      aw_ready = ($urandom % 3) != 0;
      if (aw_valid && aw_ready) begin
        wr_idx = aw.addr[9:2];
        wr_beat = 0;
        check_value("aw.len", aw.len, 8'(BURST_BEATS - 1));
      end
      w_ready = ($urandom % 3) != 0;
      if (w_valid && w_ready) begin
        check_value("w.last", w.last, wr_beat == BURST_BEATS - 1);
        mem[wr_idx] = w.data;
        wr_idx = wr_idx + 8'd1;
        wr_beat = wr_beat + 1;
        if (w.last) b_pend = 1'b1;
      end
      b_valid = 1'b0;
      if (b_pend && b_ready && ($urandom % 2)) begin   // Random response delay
        b_valid = 1'b1;
        b_resp = force_b_err ? 2'b10 : RESP_OKAY;
        b_pend = 1'b0;
      end
      ar_ready = ($urandom % 3) != 0;
      if (ar_valid && ar_ready) begin
        rd_idx = ar.addr[9:2];
        rd_beat = 0;
        r_pend = 1'b1;
        check_value("ar.len", ar.len, 8'(BURST_BEATS - 1));
      end
      r_valid = 1'b0;
      if (r_pend && r_ready && ($urandom % 2)) begin
        r_valid = 1'b1;
        r = '{data: mem[rd_idx], resp: force_r_err ? 2'b10 : RESP_OKAY, last: rd_beat == 3};
        rd_idx = rd_idx + 8'd1;
        rd_beat = rd_beat + 1;
        if (rd_beat == BURST_BEATS) r_pend = 1'b0;
      end
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > MAX_CYCLES) begin
      $display("Timeout after %0d cycles, an engine never finished", MAX_CYCLES);
      $display("Result: FAILED");
      $finish;
    end
  end

  //------------------------------
  // Helpers
  //------------------------------
  function automatic logic [31:0] expected_word(logic [31:0] init, logic [1:0] pat, int k);
    return (pat == PAT_INCR) ? init + 32'(k) : init;
  endfunction

  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      errors = errors + 1;
      $display("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp);
    end
  endtask

  task automatic reg_write(logic [7:0] addr, logic [31:0] data);
    @(negedge clk);
    req = '{wr: 1'b1, rd: 1'b0, addr: addr, wdata: data};
    @(negedge clk);
    req = '0;
    if (rsp.valid) begin
      errors = errors + 1;
      $display("Register write at %h gave a read response", addr);
    end
  endtask

  task automatic reg_read(logic [7:0] addr, output logic [31:0] data);
    @(negedge clk);
    req = '{wr: 1'b0, rd: 1'b1, addr: addr, wdata: 32'b0};
    @(negedge clk);
    req = '0;
    if (!rsp.valid) begin
      errors = errors + 1;
      $display("Register read at %h gave no response", addr);
    end
    data = rsp.rdata;
  endtask

  task automatic expect_reg(string name, logic [7:0] addr, logic [31:0] exp);
    logic [31:0] val;
    reg_read(addr, val);
    check_value(name, val, exp);
  endtask

  // Start both engines and poll until the given done bits are set
  task automatic run_engines(logic [31:0] wr_num, logic [31:0] rd_num);
    logic [31:0] st;
    reg_write(REG_WR_NUM, wr_num);
    reg_write(REG_RD_NUM, rd_num);
    reg_write(REG_CTRL, 32'h1);
    st = '0;
    while (st[1:0] != 2'b11) reg_read(REG_STATUS, st);
  endtask

  //------------------------------
  // Directed tests
  //------------------------------
  task automatic test_reset_values();
    expect_reg("STATUS", REG_STATUS, 32'h0);
    expect_reg("AR_CNT", REG_AR_CNT, 32'h0);
    expect_reg("R_CNT", REG_R_CNT, 32'h0);
    expect_reg("AW_CNT", REG_AW_CNT, 32'h0);
    expect_reg("B_CNT", REG_B_CNT, 32'h0);
    expect_reg("TYPE", REG_TYPE, 32'h0000_10c5);
    expect_reg("VER", REG_VER, 32'h0002_0001);
  endtask

  task automatic test_write_incr();
    reg_write(REG_TGT, 32'h100);
    reg_write(REG_WR_INIT, 32'h1000);
    reg_write(REG_WR_PAT, PAT_INCR);
    run_engines(3, 0);
    for (int k = 0; k < 12; k++) begin
      check_value("mem", mem[8'h40 + k], expected_word(32'h1000, PAT_INCR, k));
    end
    expect_reg("AW_CNT", REG_AW_CNT, 32'd3);
    expect_reg("B_CNT", REG_B_CNT, 32'd3);
    expect_reg("STATUS", REG_STATUS, 32'h3);   // Both done, no error
  endtask

  task automatic test_read_check();
    reg_write(REG_SRC, 32'h100);
    reg_write(REG_RD_INIT, 32'h1000);
    reg_write(REG_RD_PAT, PAT_INCR);
    run_engines(0, 3);
    expect_reg("STATUS", REG_STATUS, 32'h3);
    expect_reg("AR_CNT", REG_AR_CNT, 32'd3);
    expect_reg("R_CNT", REG_R_CNT, 32'd3);
  endtask

  task automatic test_read_mismatch();
    mem[8'h46] = 32'hdead_beef;               // Beat 6 of the run
    run_engines(0, 3);
    expect_reg("STATUS", REG_STATUS, 32'h13);
    expect_reg("ERR_ADDR", REG_ERR_ADDR, 32'h118);
    expect_reg("ERR_DATA", REG_ERR_DATA, 32'hdead_beef);
    mem[8'h46] = expected_word(32'h1000, PAT_INCR, 6);
  endtask

  task automatic test_wrap_const();
    for (int i = 8'h78; i < 8'h98; i++) mem[i] = {24'h5a5a5a, 8'(i)};
    reg_write(REG_TGT, 32'h200);
    reg_write(REG_CFG, 32'h11);               // Wrap after 2 bursts
    reg_write(REG_WR_INIT, 32'h77);
    reg_write(REG_WR_PAT, PAT_CONST);
    run_engines(5, 0);
    for (int i = 8'h78; i < 8'h98; i++) begin
      if (i >= 8'h80 && i < 8'h88) check_value("mem", mem[i], 32'h77);
      else check_value("mem", mem[i], {24'h5a5a5a, 8'(i)});
    end
    reg_write(REG_CFG, 32'h0);
  endtask

  task automatic test_error_resp();
    reg_write(REG_TGT, 32'h300);
    reg_write(REG_WR_INIT, 32'h2000);
    reg_write(REG_WR_PAT, PAT_INCR);
    force_b_err = 1'b1;
    run_engines(1, 0);
    force_b_err = 1'b0;
    expect_reg("STATUS", REG_STATUS, 32'h0b);
    expect_reg("ERR_ADDR", REG_ERR_ADDR, 32'h300);
    reg_write(REG_SRC, 32'h300);
    reg_write(REG_RD_INIT, 32'h2000);
    force_r_err = 1'b1;
    run_engines(0, 1);
    force_r_err = 1'b0;
    expect_reg("STATUS", REG_STATUS, 32'h23);
  endtask

  initial begin
    void'($urandom(32'h91c6));
    {aw_ready, w_ready, b_valid, ar_ready, r_valid} = '0;
    b_resp = RESP_OKAY;
    r = '0;
    req = '0;
    errors = 0;
    cycles = 0;
    force_b_err = 1'b0;
    force_r_err = 1'b0;
    for (int i = 0; i < 256; i++) mem[i] = {24'hc3c3c3, 8'(i)};
    rst = 1'b1;
    repeat (2) @(negedge clk);
    rst = 1'b0;
    test_reset_values();
    test_write_incr();
    test_read_check();
    test_read_mismatch();
    test_wrap_const();
    test_error_resp();
    $display("Checks finished with %0d errors and %0d assertion failures",
             errors, i_hdl_computing.u_props.fail_cnt);
    if (errors == 0 && i_hdl_computing.u_props.fail_cnt == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
